/* flist.f */
+incdir+src
+incdir+tests
src/fanout_pkg.sv
src/command_resync.sv
src/frame_lock.sv
src/frame_regenerator.sv
src/command_lane.sv
src/fast_command_fanout.sv
tests/tb_fast_command_fanout.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fast command fanout testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fast_command_fanout

rm -rf obj_dir "$LOG"

verilator --binary --timing -f flist.f --top-module "$TOP" -o sim_"$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

/* tests/fanout_checker.svh */
`ifndef FANOUT_CHECKER_SVH
`define FANOUT_CHECKER_SVH

////////////////////////////////////////
// Frame reference model
////////////////////////////////////////
// MSB is the oldest bit, so frame bit k from the oldest is f[7-k]
function automatic logic [`FRAME_BITS-1:0] model_frame(input logic [`FRAME_BITS-1:0] sent);
    logic header_good;
    logic trailer_good;
    logic payload_clean;
    header_good   = (sent[7:5] == 3'b110);                       // Header 1,1,0
    trailer_good  = sent[0];                                     // Closing 1
    payload_clean = (sent[4:2] != 3'b110) && (sent[5:3] != 3'b110); // Bits 3..5 and 2..4
    if (header_good && trailer_good && payload_clean)
    begin
        return sent;                                             // Passed through as is
    end
    return 8'b11000001;                                          // Idle substitute
endfunction

////////////////////////////////////////
// Failure reporting
////////////////////////////////////////
task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at %0t ns", $time);
endtask

task automatic report_mismatch(input string name, input string got, input string exp);
    $display("ERROR at %0t ns: %s is %s, expected %s", $time, name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped on first mismatch");
endtask

////////////////////////////////////////
// Typed compare tasks
////////////////////////////////////////
task automatic compare_pins(input string name,
                            input fanout_pkg::lane_pins_t got,
                            input fanout_pkg::lane_pins_t exp);
    if (got !== exp)
    begin
        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp)); // p n clk_p clk_n
    end
endtask

task automatic compare_status(input string name,
                              input fanout_pkg::lock_status_t got,
                              input fanout_pkg::lock_status_t exp);
    if (got !== exp)
    begin
        report_mismatch(name, $sformatf("locked %b phase %0d", got.locked, got.phase),
                        $sformatf("locked %b phase %0d", exp.locked, exp.phase));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
endtask

task automatic compare_frame(input string name,
                             input logic [`FRAME_BITS-1:0] got,
                             input logic [`FRAME_BITS-1:0] exp);
    if (got !== exp)
    begin
        report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
endtask

`endif

/* tests/tb_fast_command_fanout.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module tb_fast_command_fanout;

    `include "fanout_checker.svh"

    localparam int N_FRAMES    = 200;                 // Frames in the checked run
    localparam int N_FLUSH     = 4;                   // Idle frames to drain the pipe
    localparam int N_WARMUP    = 24;                  // Clean idle frames to settle lock
    localparam int FALSE_IDX   = 100;                 // Frame with 110 in its payload
    localparam int CHECK_FROM  = 8;
    localparam int ALIGN_FROM  = 24;
    localparam int ALIGN_LEN   = 24;
    localparam int MAX_DELAY   = 4;                   // Pipeline depth in whole frames
    localparam int LOCK_CYCLE  = 32;                  // Lock must hold from here on
    // Bit count on the edge that sees the first header: resync flops, eight shifts
    // into the window, one capture edge, and the counter starts one ahead
    localparam int LOCK_PHASE  = (`RESYNC_STAGES + `FRAME_BITS + 2) % `FRAME_BITS;
    localparam int TIMEOUT_NS  = ((N_FRAMES + N_FLUSH) * `FRAME_BITS + 8 + 200) * 20;
    localparam logic [`N_LANES-1:0] LANE_INV = `LANE_INVERT;

    logic                                  fast_clock_in;
    logic                                  arstn;
    logic                                  fast_command_in;
    fanout_pkg::lane_pins_t [`N_LANES-1:0] pins;
    fanout_pkg::lock_status_t              status;

    logic [31:0]            lfsr_state;
    logic [`FRAME_BITS-1:0] frames [N_FRAMES+N_FLUSH];
    logic                   out_bits [$];          // Lane 0, polarity undone
    logic                   monitor_on;
    int                     cycle;

    fast_command_fanout DUT (
        .fast_clock_in(fast_clock_in),
        .arstn(arstn),
        .fast_command_in(fast_command_in),
        .pins(pins),
        .status(status)
    );

    initial fast_clock_in = 1'b0;
    always #10 fast_clock_in = ~fast_clock_in;     // 20 ns period

    ////////////////////////////////////////
    // Stimulus source
    ////////////////////////////////////////
    function automatic logic next_random_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};       // Taps 32 22 2 1
        return fb;
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[6:0], next_random_bit()};
        end
        return r;
    endfunction

    task automatic build_frames();
        logic [7:0] sel;
        logic [7:0] hdr;
        logic [7:0] pay;
        for (int f = 0; f < N_FRAMES + N_FLUSH; f++)
        begin
            if (f < N_WARMUP || f >= N_FRAMES)
            begin
                frames[f] = `IDLE_FRAME;           // No off-phase headers in idle runs
            end
            else if (f == FALSE_IDX)
            begin
                pay       = random_bits(1);
                frames[f] = {3'b110, 3'b110, pay[0], 1'b1};
            end
            else if (random_bits(3) == 8'd0)
            begin
                sel = random_bits(2);              // Pick a corruption kind
                if (sel == 8'd0)
                begin
                    hdr = random_bits(3);
                    if (hdr == 8'd0)
                    begin
                        hdr = 8'd1;
                    end
                    pay       = random_bits(4);
                    frames[f] = {3'b110 ^ hdr[2:0], pay[3:0], 1'b1};
                end
                else if (sel == 8'd1)
                begin
                    pay       = random_bits(4);
                    frames[f] = {3'b110, pay[3:0], 1'b0}; // Bad trailer
                end
                else
                begin
                    pay       = random_bits(1);
                    frames[f] = {3'b110, 3'b110, pay[0], 1'b1};
                end
            end
            else
            begin
                pay       = random_bits(4);
                frames[f] = {3'b110, pay[3:0], 1'b1};
            end
        end
    endtask

    ////////////////////////////////////////
    // Reset and output checks
    ////////////////////////////////////////
    task automatic check_reset_state();
        fanout_pkg::lane_pins_t exp;
        exp.cmd_p = 1'b0;
        exp.cmd_n = 1'b1;
        exp.clk_p = 1'b0;
        exp.clk_n = 1'b0;                          // Clocks held low
        for (int i = 0; i < `N_LANES; i++)
        begin
            compare_pins($sformatf("pins[%0d]", i), pins[i], exp);
        end
        compare_bit("status.locked", status.locked, 1'b0);
    endtask

    function automatic logic [`FRAME_BITS-1:0] output_frame(input int offset, input int idx);
        logic [`FRAME_BITS-1:0] r;
        int base;
        base = offset + `FRAME_BITS * idx;
        if (base + `FRAME_BITS > out_bits.size())
        begin
            return 'x;                             // Not captured yet
        end
        for (int k = 0; k < `FRAME_BITS; k++)
        begin
            r[`FRAME_BITS-1-k] = out_bits[base+k];
        end
        return r;
    endfunction

    task automatic check_output_frames();
        int  offset;
        int  delay;
        logic found;
        logic ok;
        found = 1'b0;
        offset = 0;
        delay = 0;
        for (int d = 0; d <= MAX_DELAY; d++)
        begin
            for (int o = 0; o < `FRAME_BITS; o++)
            begin
                ok = 1'b1;
                for (int e = ALIGN_FROM; e < ALIGN_FROM + ALIGN_LEN; e++)
                begin
                    if (output_frame(o, e + d) !== model_frame(frames[e]))
                    begin
                        ok = 1'b0;
                    end
                end
                if (ok && !found)
                begin
                    found  = 1'b1;
                    offset = o;
                    delay  = d;
                end
            end
        end
        if (!found)
        begin
            stop_with_failure("Lane 0 output never lined up with the frames that were sent");
        end
        for (int e = CHECK_FROM; e < N_FRAMES; e++)
        begin
            compare_frame($sformatf("lane 0 frame %0d", e), output_frame(offset, e + delay),
                          model_frame(frames[e]));
        end
        // Payload 110 must come back as idle even with a good header
        compare_frame("false header frame", output_frame(offset, FALSE_IDX + delay),
                      `IDLE_FRAME);
    endtask

    always @(negedge fast_clock_in)
    begin
        fanout_pkg::lane_pins_t   exp;
        fanout_pkg::lock_status_t exp_status;
        logic lane0;
        #5;                                        // Middle of the low half, pins settled
        if (monitor_on)
        begin
            lane0 = pins[0].cmd_p ^ LANE_INV[0];   // Back to the clean stream
            out_bits.push_back(lane0);
            for (int i = 0; i < `N_LANES; i++)
            begin
                exp.cmd_p = lane0 ^ LANE_INV[i];
                exp.cmd_n = ~exp.cmd_p;
                exp.clk_p = 1'b0;                  // Clock low in this half
                exp.clk_n = 1'b1;
                compare_pins($sformatf("pins[%0d]", i), pins[i], exp);
            end
            if (cycle >= LOCK_CYCLE)
            begin
                exp_status.locked = 1'b1;
                exp_status.phase  = LOCK_PHASE[2:0]; // Phase of the first header
                compare_status("status", status, exp_status);
            end
            cycle++;
        end
    end

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////
    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        arstn           = 1'b0;
        fast_command_in = 1'b0;
        monitor_on      = 1'b0;
        cycle           = 0;
        lfsr_state      = 32'hb958;
        build_frames();
        repeat (8)
        begin
            @(negedge fast_clock_in);
            check_reset_state();
        end
        @(posedge fast_clock_in);
        arstn <= 1'b1;
        @(negedge fast_clock_in);
        check_reset_state();                       // No active edge seen yet
        @(posedge fast_clock_in);
        monitor_on <= 1'b1;
        for (int f = 0; f < N_FRAMES + N_FLUSH; f++)
        begin
            for (int b = `FRAME_BITS - 1; b >= 0; b--)
            begin
                fast_command_in <= frames[f][b];   // Oldest bit first
                @(posedge fast_clock_in);
            end
        end
        monitor_on <= 1'b0;
        @(posedge fast_clock_in);
        check_output_frames();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* src/fast_command_fanout.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module fast_command_fanout
(
    input  logic                                 fast_clock_in,
    input  logic                                 arstn,
    input  logic                                 fast_command_in,  // Serial command in
    output fanout_pkg::lane_pins_t [`N_LANES-1:0] pins,            // One pin group per lane
    output fanout_pkg::lock_status_t             status            // Frame lock state
);

    localparam logic [`N_LANES-1:0] LANE_INV = `LANE_INVERT;

    logic               sync_command;             // Re-timed input
    fanout_pkg::frame_t frame;                    // Lock to regenerator handoff
    logic               clean_command;            // Stream sent to every lane

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////
    command_resync #(
        .STAGES(`RESYNC_STAGES)
    ) u_resync (
        .fast_clock_in(fast_clock_in),
        .arstn(arstn),
        .command(fast_command_in),
        .sync_command(sync_command)
    );

    frame_lock u_lock (
        .fast_clock_in(fast_clock_in),
        .arstn(arstn),
        .sync_command(sync_command),
        .frame(frame),
        .status(status)
    );

    frame_regenerator u_regen (
        .fast_clock_in(fast_clock_in),
        .arstn(arstn),
        .frame(frame),
        .clean_command(clean_command)
    );

    ////////////////////////////////////////
    // Output lanes
    ////////////////////////////////////////
    generate
    for (genvar i = 0; i < `N_LANES; i++)
    begin : g_lane
        command_lane #(
            .INVERT(LANE_INV[i])                  // Per-lane polarity
        ) u_lane (
            .fast_clock_in(fast_clock_in),
            .arstn(arstn),
            .clean_command(clean_command),
            .pins(pins[i])
        );
    end
    endgenerate

endmodule

/* src/command_lane.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module command_lane #(
    parameter logic INVERT = 1'b0                 // Pair swapped on the board
)
(
    input  logic                   fast_clock_in,
    input  logic                   arstn,
    input  logic                   clean_command,  // Shared regenerated stream
    output fanout_pkg::lane_pins_t pins            // Differential command and clock
);

    logic cmd_q;                                  // Output command flop
    logic run;                                    // Clock forwarding enable
    logic fwd_clk;

    ////////////////////////////////////////
    // Command output
    ////////////////////////////////////////
    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            cmd_q <= 1'b0;                        // Both polarities start at 0 on _p
        end
        else
        begin
            cmd_q <= clean_command ^ INVERT;      // Undo the board swap here
        end
    end

    ////////////////////////////////////////
    // Forwarded clock
    ////////////////////////////////////////
    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            run <= 1'b0;
        end
        else
        begin
            run <= 1'b1;                          // Set on first edge after reset
        end
    end

    assign fwd_clk = fast_clock_in & run;         // Held low while stopped

    assign pins.cmd_p = cmd_q;
    assign pins.cmd_n = ~cmd_q;
    assign pins.clk_p = fwd_clk;
    assign pins.clk_n = ~fast_clock_in & run;     // Complement, also low when stopped

endmodule

/* src/frame_regenerator.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module frame_regenerator
(
    input  logic               fast_clock_in,
    input  logic               arstn,
    input  fanout_pkg::frame_t frame,             // Window and flags from the lock
    output logic               clean_command      // Regenerated serial stream
);

    logic [`FRAME_BITS:0]   out_sr;               // MSB is the bit on the wire
    logic [2:0]             window_a;             // Frame bits 3..5 from the oldest
    logic [2:0]             window_b;             // Frame bits 2..4 from the oldest
    logic                   false_header;
    logic                   frame_good;
    logic [`FRAME_BITS-1:0] next_frame;

    ////////////////////////////////////////
    // Frame screening
    ////////////////////////////////////////
    // Oldest bit is bits[FRAME_BITS-1], so bit k from the oldest is bits[FRAME_BITS-1-k]
    assign window_a = frame.bits[`FRAME_BITS-4 -: 3];
    assign window_b = frame.bits[`FRAME_BITS-3 -: 3];

    // Payload that looks like a header would confuse the receiver's own lock
    assign false_header = (window_a == `HEADER_PATTERN) || (window_b == `HEADER_PATTERN);
    assign frame_good   = frame.header_ok && !false_header;
    assign next_frame   = frame_good ? frame.bits : `IDLE_FRAME;

    ////////////////////////////////////////
    // Output shifter
    ////////////////////////////////////////
    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            out_sr <= '0;                         // Line idles low until first strobe
        end
        else if (frame.strobe)
        begin
            // Last bit of the previous frame still has to leave through the MSB
            out_sr <= {out_sr[`FRAME_BITS-1], next_frame};
        end
        else
        begin
            out_sr <= {out_sr[`FRAME_BITS-1:0], 1'b0}; // Shift out, fill with zeros
        end
    end

    assign clean_command = out_sr[`FRAME_BITS];

endmodule

/* src/frame_lock.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module frame_lock
(
    input  logic                     fast_clock_in,
    input  logic                     arstn,
    input  logic                     sync_command,   // Re-timed serial stream
    output fanout_pkg::frame_t       frame,          // Current window plus flags
    output fanout_pkg::lock_status_t status          // Lock flag and stored phase
);

    localparam int CTR_BITS = $clog2(`FRAME_BITS);

    logic [`FRAME_BITS:0]  in_sr;                    // One spare bit below the frame
    logic [CTR_BITS-1:0]   bit_ctr;                  // Free running position in frame
    logic [CTR_BITS-1:0]   phase;                    // Bit count where a frame ends
    logic [`LOCK_BITS-1:0] lock_count;               // Confidence in the phase
    logic                  header_match;
    logic                  on_phase;

    ////////////////////////////////////////
    // Header detection
    ////////////////////////////////////////
    // Window is in_sr[FRAME_BITS:1], header sits in the three oldest bits
    // and the newest frame bit must be the closing 1
    assign header_match = (in_sr[`FRAME_BITS -: 3] == `HEADER_PATTERN) && in_sr[1];
    assign on_phase     = (bit_ctr == phase);

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            in_sr <= '0;                             // Keeps the header check defined
        end
        else
        begin
            in_sr <= {in_sr[`FRAME_BITS-1:0], sync_command}; // Oldest bit moves to MSB
        end
    end

    ////////////////////////////////////////
    // Phase search and lock counter
    ////////////////////////////////////////
    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            bit_ctr    <= '0;
            phase      <= '0;
            lock_count <= '0;
        end
        else
        begin
            bit_ctr <= bit_ctr + 1'b1;               // Wraps once per frame

            if (lock_count == '0)
            begin
                // Unlocked, grab the first header we see
                if (header_match)
                begin
                    phase      <= bit_ctr;
                    lock_count <= `LOCK_BITS'(1);
                end
            end
            else if (on_phase)
            begin
                if (header_match)
                begin
                    if (lock_count != '1)
                    begin
                        lock_count <= lock_count + 1'b1; // Saturate at all ones
                    end
                end
                else
                begin
                    lock_count <= lock_count - 1'b1;     // Expected header missing
                end
            end
            else if (header_match)
            begin
                lock_count <= lock_count - 1'b1;         // Header seen off phase
            end
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////
    assign frame.strobe    = on_phase;               // One cycle in eight
    assign frame.header_ok = header_match;
    assign frame.bits      = in_sr[`FRAME_BITS:1];   // Whole frame, oldest at MSB

    assign status.locked   = (lock_count != '0);
    assign status.phase    = phase;

endmodule

/* src/command_resync.sv */
`timescale 1ns/1ps
`include "fanout_settings.svh"

module command_resync #(
    parameter int STAGES = `RESYNC_STAGES         // Flop count, 0 is a plain wire
)
(
    input  logic fast_clock_in,
    input  logic arstn,
    input  logic command,                         // Raw serial command from the pin
    output logic sync_command                     // Same stream, re-timed
);

    generate
    if (STAGES == 0)
    begin : g_bypass
        // Source already on this clock, nothing to re-time
        assign sync_command = command;
    end
    else
    begin : g_chain
        logic [STAGES-1:0] chain;                 // chain[0] samples the pin

        ////////////////////////////////////////
        // Flop chain
        ////////////////////////////////////////
        always_ff @(posedge fast_clock_in or negedge arstn)
        begin
            if (!arstn)
            begin
                chain <= '0;                      // Quiet line out of reset
            end
            else
            begin
                chain[0] <= command;              // First stage takes the pin
                for (int i = 1; i < STAGES; i++)
                begin
                    chain[i] <= chain[i-1];       // Walk one stage per cycle
                end
            end
        end

        assign sync_command = chain[STAGES-1];    // Last stage feeds the lock
    end
    endgenerate

endmodule

/* src/fanout_pkg.sv */
`include "fanout_settings.svh"

package fanout_pkg;

    ////////////////////////////////////////
    // Frame handoff from lock to regenerator
    ////////////////////////////////////////
    typedef struct packed
    {
        logic                   strobe;     // High on the locked phase only
        logic                   header_ok;  // Header and trailing 1 both seen
        logic [`FRAME_BITS-1:0] bits;       // MSB is the oldest bit on the wire
    } frame_t;

    // Pins of a single output lane
    typedef struct packed
    {
        logic cmd_p;                        // Command, true side
        logic cmd_n;                        // Command, complement side
        logic clk_p;                        // Forwarded clock, true side
        logic clk_n;                        // Forwarded clock, complement side
    } lane_pins_t;

    ////////////////////////////////////////
    // Lock state reported at the top
    ////////////////////////////////////////
    typedef struct packed
    {
        logic                           locked; // Lock counter is non-zero
        logic [$clog2(`FRAME_BITS)-1:0] phase;  // Bit count where frames end
    } lock_status_t;

endpackage

/* src/fanout_settings.svh */
`ifndef FANOUT_SETTINGS_SVH
`define FANOUT_SETTINGS_SVH

////////////////////////////////////////
// Fanout geometry
////////////////////////////////////////
`define N_LANES 4                  // Output lanes driven from the clean stream
`define LANE_INVERT 4'b0101        // One bit per lane, set where the board swaps the pair
`define RESYNC_STAGES 2            // Input flops, 0 means straight through

////////////////////////////////////////
// Fast command framing
////////////////////////////////////////
`define FRAME_BITS 8               // Bits per command frame
`define LOCK_BITS 6                // Width of the saturating lock counter
`define HEADER_PATTERN 3'b110      // First three bits of every frame
`define IDLE_FRAME 8'b11000001     // Sent in place of anything suspicious

`endif
